// File: periph_pkg.sv
/*
  Shared address view, slot numbers and register offsets for the peripheral hub.
  Full slots take 64-byte windows and byte slots take 16-byte windows.
  Addresses with bits 10:9 = 2'b11 fall outside both views and read as zero.
*/
`default_nettype none

package periph_pkg;

    // Full slot view of the 11-bit address
    typedef struct packed {
        logic       region;
        logic [3:0] slot;
        logic [5:0] offset;
    } full_addr_t;

    // Byte slot view, bit 8 is not decoded
    typedef struct packed {
        logic [1:0] region;
        logic       rsvd;
        logic [3:0] slot;
        logic [3:0] offset;
    } byte_addr_t;

    typedef union packed {
        full_addr_t full_v;
        byte_addr_t byte_v;
    } periph_addr_u;

    // Bit 4 picks a byte slot, bits 3:0 the slot number
    typedef logic [4:0] pin_sel_t;

    localparam logic [1:0] ACC_NONE    = 2'b11;
    localparam logic [1:0] REGION_BYTE = 2'b10;

    localparam logic [3:0] SLOT_GPIO  = 4'd1;
    localparam logic [3:0] SLOT_TIMER = 4'd2;
    localparam logic [3:0] SLOT_EDGE  = 4'd0;
    localparam logic [3:0] SLOT_PWM   = 4'd1;

    localparam logic [5:0] GPIO_OFS_OUT = 6'h00;
    localparam logic [5:0] GPIO_OFS_IN  = 6'h04;
    localparam logic [5:0] GPIO_OFS_SEL = 6'h20;

endpackage

`default_nettype wire

// File: periph_if.sv
/*
  Link between the bus controller and one peripheral slot.
  wr is already qualified by slot selection; rdata must be combinational.
*/
`timescale 1ns/1ns
`default_nettype none

interface periph_if;

    logic        wr;
    logic [5:0]  offset;
    logic [31:0] wdata;
    logic [31:0] rdata;

    modport ctrl (
        output wr,
        output offset,
        output wdata,
        input  rdata
    );

    modport periph (
        input  wr,
        input  offset,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: bus_ctrl.sv
/*
  Address decode, write strobes and registered read return.
  Read data is captured once per request and held until read complete.
  Access size only marks a lane as active; byte slots return the low byte.
*/
`timescale 1ns/1ns
`default_nettype none

module bus_ctrl
    import periph_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire periph_addr_u i_addr,
    input  wire logic [31:0]  i_data_in,
    input  wire logic [1:0]   i_data_write_n,
    input  wire logic [1:0]   i_data_read_n,
    input  wire logic         i_data_read_complete,
    output logic      [31:0]  o_data_out,
    output logic              o_data_ready,
    periph_if.ctrl            gpio_bus,
    periph_if.ctrl            timer_bus,
    periph_if.ctrl            edge_bus,
    periph_if.ctrl            pwm_bus
);

    logic        write_act;
    logic        read_req;
    logic        is_full;
    logic        is_byte;
    logic        capture;
    logic        data_hold;
    logic        ready_r;
    logic [31:0] rd_mux;
    logic [31:0] data_out_r;

    assign write_act = (i_data_write_n != ACC_NONE);
    assign read_req  = (i_data_read_n != ACC_NONE);

    // Region 2'b11 matches neither view
    assign is_full = (i_addr.full_v.region == 1'b0);
    assign is_byte = (i_addr.byte_v.region == REGION_BYTE);

    assign gpio_bus.wr  = write_act && is_full && (i_addr.full_v.slot == SLOT_GPIO);
    assign timer_bus.wr = write_act && is_full && (i_addr.full_v.slot == SLOT_TIMER);
    assign edge_bus.wr  = write_act && is_byte && (i_addr.byte_v.slot == SLOT_EDGE);
    assign pwm_bus.wr   = write_act && is_byte && (i_addr.byte_v.slot == SLOT_PWM);

    assign gpio_bus.offset  = i_addr.full_v.offset;
    assign timer_bus.offset = i_addr.full_v.offset;
    assign edge_bus.offset  = {2'b00, i_addr.byte_v.offset};
    assign pwm_bus.offset   = {2'b00, i_addr.byte_v.offset};

    assign gpio_bus.wdata  = i_data_in;
    assign timer_bus.wdata = i_data_in;
    assign edge_bus.wdata  = i_data_in;
    assign pwm_bus.wdata   = i_data_in;

    // Unused slots fall through to zero
    always_comb begin
        rd_mux = '0;
        if (is_full) begin
            case (i_addr.full_v.slot)
                SLOT_GPIO:  rd_mux = gpio_bus.rdata;
                SLOT_TIMER: rd_mux = timer_bus.rdata;
                default:    rd_mux = '0;
            endcase
        end else if (is_byte) begin
            case (i_addr.byte_v.slot)
                SLOT_EDGE: rd_mux = {24'h0, edge_bus.rdata[7:0]};
                SLOT_PWM:  rd_mux = {24'h0, pwm_bus.rdata[7:0]};
                default:   rd_mux = '0;
            endcase
        end
    end

    // Only the first cycle of a request samples the peripheral
    assign capture = read_req && !data_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold <= 1'b0;
            ready_r   <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                data_hold <= 1'b0;
            end
            if (capture) begin
                data_hold <= 1'b1;
            end
            ready_r <= read_req;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_out_r <= rd_mux;
        end
    end

    assign o_data_out   = data_out_r;
    // Writes never stall
    assign o_data_ready = ready_r || write_act;

endmodule

`default_nettype wire

// File: gpio_block.sv
/*
  GPIO output and input registers plus the per-pin function select.
  Pin n select lives at offset 0x20 + 4n. Selects that name an unused
  slot drive the pin low. After reset pin 0 follows the timer.
*/
`timescale 1ns/1ns
`default_nettype none

module gpio_block
    import periph_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    periph_if.periph        bus,
    input  wire logic [7:0] i_ui_in,
    input  wire logic [7:0] i_timer_pins,
    input  wire logic [7:0] i_pwm_pins,
    input  wire logic [7:0] i_edge_pins,
    output logic      [7:0] o_uo_out
);

    logic [7:0]  gpio_out;
    pin_sel_t    pin_sel [8];
    logic        sel_hit;
    logic [2:0]  sel_idx;
    logic [31:0] rd_word;

    // Offsets 0x20, 0x24 ... 0x3c
    assign sel_hit = ((bus.offset & ~6'h1c) == GPIO_OFS_SEL);
    assign sel_idx = bus.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int i = 0; i < 8; i++) begin
                pin_sel[i] <= (i == 0) ? {1'b0, SLOT_TIMER} : {1'b0, SLOT_GPIO};
            end
        end else if (bus.wr) begin
            if (bus.offset == GPIO_OFS_OUT) begin
                gpio_out <= bus.wdata[7:0];
            end
            if (sel_hit) begin
                pin_sel[sel_idx] <= bus.wdata[4:0];
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (bus.offset == GPIO_OFS_OUT) begin
            rd_word = {24'h0, gpio_out};
        end else if (bus.offset == GPIO_OFS_IN) begin
            rd_word = {24'h0, i_ui_in};
        end else if (sel_hit) begin
            rd_word = {27'h0, pin_sel[sel_idx]};
        end
    end

    assign bus.rdata = rd_word;

    // Each pin takes its own bit of the selected source
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            o_uo_out[i] = 1'b0;
            if (pin_sel[i][4]) begin
                case (pin_sel[i][3:0])
                    SLOT_EDGE: o_uo_out[i] = i_edge_pins[i];
                    SLOT_PWM:  o_uo_out[i] = i_pwm_pins[i];
                    default:   o_uo_out[i] = 1'b0;
                endcase
            end else begin
                case (pin_sel[i][3:0])
                    SLOT_GPIO:  o_uo_out[i] = gpio_out[i];
                    SLOT_TIMER: o_uo_out[i] = i_timer_pins[i];
                    default:    o_uo_out[i] = 1'b0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: event_timer.sv
/*
  Microsecond countdown timer. A write at offset 0 loads the count and
  restarts the prescaler; the interrupt is sticky until a write at offset 4
  or a reload. CLOCK_MHZ must be at least 1.
*/
`timescale 1ns/1ns
`default_nettype none

module event_timer #(
    parameter int CLOCK_MHZ = 64
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    periph_if.periph   bus,
    output logic [7:0] o_pins,
    output logic       o_irq
);

    localparam int         PRE_W     = (CLOCK_MHZ > 1) ? $clog2(CLOCK_MHZ) : 1;
    localparam logic [5:0] OFS_COUNT = 6'h00;
    localparam logic [5:0] OFS_IRQ   = 6'h04;

    logic [PRE_W-1:0] pre_cnt;
    logic [31:0]      count;
    logic             tick;
    logic             irq_r;
    logic             toggle;
    logic             load;

    assign load = bus.wr && (bus.offset == OFS_COUNT);
    assign tick = (pre_cnt == PRE_W'(CLOCK_MHZ - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            count   <= '0;
            irq_r   <= 1'b0;
            toggle  <= 1'b0;
        end else if (load) begin
            pre_cnt <= '0;
            count   <= bus.wdata;
            irq_r   <= 1'b0;
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (bus.wr && bus.offset == OFS_IRQ) begin
                irq_r <= 1'b0;
            end
            if (tick && count != '0) begin
                count <= count - 1'b1;
                // Expiry wins over a clear in the same cycle
                if (count == 32'd1) begin
                    irq_r  <= 1'b1;
                    toggle <= ~toggle;
                end
            end
        end
    end

    assign bus.rdata = (bus.offset == OFS_COUNT) ? count :
                       (bus.offset == OFS_IRQ)   ? {31'h0, irq_r} : 32'h0;

    assign o_pins = {8{toggle}};
    assign o_irq  = irq_r;

endmodule

`default_nettype wire

// File: edge_counter.sv
/*
  Eight 8-bit rising-edge counters, one per input pin, wrapping at 256.
  Offset n reads counter n; a write to offset n clears it.
  Inputs are assumed already synchronized to clk.
*/
`timescale 1ns/1ns
`default_nettype none

module edge_counter (
    input  wire logic       clk,
    input  wire logic       rst_n,
    periph_if.periph        bus,
    input  wire logic [7:0] i_ui_in,
    output logic      [7:0] o_pins
);

    logic [7:0] ui_q;
    logic [7:0] rise;
    logic [7:0] cnt [8];

    assign rise = i_ui_in & ~ui_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ui_q <= '0;
            for (int i = 0; i < 8; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            ui_q <= i_ui_in;
            for (int i = 0; i < 8; i++) begin
                // Clear takes priority over a coincident edge
                if (bus.wr && bus.offset[3:0] == 4'(i)) begin
                    cnt[i] <= '0;
                end else if (rise[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign bus.rdata = bus.offset[3] ? 32'h0 : {24'h0, cnt[bus.offset[2:0]]};

    // Registered copy lets the inputs be looped back to the pins
    assign o_pins = ui_q;

endmodule

`default_nettype wire

// File: pwm_gen.sv
/*
  Free-running 8-bit PWM with a 256-clock period.
  Output is high for duty clocks per period, so 255 is the highest level.
  Duty lives at offset 0.
*/
`timescale 1ns/1ns
`default_nettype none

module pwm_gen (
    input  wire logic  clk,
    input  wire logic  rst_n,
    periph_if.periph   bus,
    output logic [7:0] o_pins
);

    logic [7:0] pwm_cnt;
    logic [7:0] duty;
    logic       duty_sel;
    logic       pwm_level;

    assign duty_sel = (bus.offset[3:0] == 4'h0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
            duty    <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            if (bus.wr && duty_sel) begin
                duty <= bus.wdata[7:0];
            end
        end
    end

    assign pwm_level = (pwm_cnt < duty);

    assign bus.rdata = duty_sel ? {24'h0, duty} : 32'h0;

    // Same level on every pin so any pin can pick it up
    assign o_pins = {8{pwm_level}};

endmodule

`default_nettype wire

// File: periph_hub.sv
/*
  Peripheral hub for the microcontroller data bus.
  GPIO in full slot 1, timer in full slot 2, edge counter in byte slot 0,
  PWM in byte slot 1. No peripheral stalls, so reads always complete in one cycle.
  CLOCK_MHZ must equal the number of clocks per microsecond.
*/
`timescale 1ns/1ns
`default_nettype none

module periph_hub
    import periph_pkg::*;
#(
    parameter int CLOCK_MHZ = 64
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [7:0]  i_ui_in,
    output logic      [7:0]  o_uo_out,
    input  wire logic [10:0] i_addr,
    input  wire logic [31:0] i_data_in,
    input  wire logic [1:0]  i_data_write_n,
    input  wire logic [1:0]  i_data_read_n,
    input  wire logic        i_data_read_complete,
    output logic      [31:0] o_data_out,
    output logic             o_data_ready,
    output logic             o_irq
);

    periph_addr_u addr_view;
    logic [7:0]   timer_pins;
    logic [7:0]   edge_pins;
    logic [7:0]   pwm_pins;

    periph_if gpio_if ();
    periph_if timer_if ();
    periph_if edge_if ();
    periph_if pwm_if ();

    assign addr_view = i_addr;

    bus_ctrl u_bus_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (addr_view),
        .i_data_in            (i_data_in),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .gpio_bus             (gpio_if.ctrl),
        .timer_bus            (timer_if.ctrl),
        .edge_bus             (edge_if.ctrl),
        .pwm_bus              (pwm_if.ctrl)
    );

    gpio_block u_gpio (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (gpio_if.periph),
        .i_ui_in      (i_ui_in),
        .i_timer_pins (timer_pins),
        .i_pwm_pins   (pwm_pins),
        .i_edge_pins  (edge_pins),
        .o_uo_out     (o_uo_out)
    );

    event_timer #(
        .CLOCK_MHZ (CLOCK_MHZ)
    ) u_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (timer_if.periph),
        .o_pins (timer_pins),
        .o_irq  (o_irq)
    );

    edge_counter u_edge (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (edge_if.periph),
        .i_ui_in (i_ui_in),
        .o_pins  (edge_pins)
    );

    pwm_gen u_pwm (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (pwm_if.periph),
        .o_pins (pwm_pins)
    );

endmodule

`default_nettype wire

// File: tb_periph_tasks.svh
/*
  Bus and pin helpers for the hub testbench, included inside tb_periph_hub.
  They drive and sample the testbench signals directly, so they must be
  included after those signals are declared. All waits step whole clocks.
*/
`ifndef TB_PERIPH_TASKS_SVH
`define TB_PERIPH_TASKS_SVH

task automatic report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
    $display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h", $time, sig, exp, act);
    error_count++;
endtask

task automatic report_problem(input string what);
    $display("Problem at %0t ns: %s", $time, what);
    error_count++;
endtask

// Inputs change 2 ns after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #2;
endtask

task automatic bus_write(input logic [10:0] adr, input logic [31:0] wdata);
    addr    = adr;
    data_in = wdata;
    write_n = 2'b10;
    #1;
    // Ready is combinational while a write is presented
    if (data_ready !== 1'b1) begin
        report_mismatch("o_data_ready during write", 32'h1, {31'h0, data_ready});
    end
    next_cycle();
    write_n = ACC_NONE;
endtask

task automatic bus_read(input logic [10:0] adr, output logic [31:0] rdata, output int latency);
    addr    = adr;
    read_n  = 2'b10;
    latency = 0;
    rdata   = '0;
    do begin
        next_cycle();
        latency++;
    end while (data_ready !== 1'b1 && latency < READ_WAIT_MAX);
    if (data_ready !== 1'b1) begin
        report_problem("read request never saw o_data_ready");
    end else begin
        rdata = data_out;
    end
    if (latency != 1) begin
        report_mismatch("read latency in cycles", 32'h1, latency);
    end
    read_n        = ACC_NONE;
    read_complete = 1'b1;
    next_cycle();
    read_complete = 1'b0;
endtask

// One clock high, one clock low per pulse
task automatic drive_pulses(input int pin, input int count);
    for (int i = 0; i < count; i++) begin
        ui_in[pin] = 1'b1;
        next_cycle();
        ui_in[pin] = 1'b0;
        next_cycle();
    end
endtask

task automatic count_high_cycles(input int pin, output int highs);
    highs = 0;
    for (int i = 0; i < 256; i++) begin
        next_cycle();
        if (uo_out[pin] === 1'b1) begin
            highs++;
        end
    end
endtask

`endif

// File: tb_periph_hub.sv
/*
  Testbench for periph_hub built with CLOCK_MHZ = 4.
  A stimulus table is filled at time zero and applied step by step.
  Random values come from a fixed seed, so every run is the same.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_periph_hub
    import periph_pkg::*;
();

    localparam int CLOCK_MHZ       = 4;
    localparam int READ_WAIT_MAX   = 4;
    localparam int CYCLES_PER_STEP = 300;

    typedef enum int {
        OP_WRITE, OP_READ, OP_SETIN, OP_PINS, OP_PULSE, OP_PWM, OP_TIMER, OP_HOLD
    } op_e;

    logic        clk;
    logic        rst_n;
    logic [7:0]  ui_in;
    logic [7:0]  uo_out;
    logic [10:0] addr;
    logic [31:0] data_in;
    logic [1:0]  write_n;
    logic [1:0]  read_n;
    logic        read_complete;
    logic [31:0] data_out;
    logic        data_ready;
    logic        irq;

    op_e         step_op   [$];
    logic [10:0] step_addr [$];
    logic [31:0] step_data [$];
    logic [31:0] step_exp  [$];
    string       step_name [$];

    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    `include "tb_periph_tasks.svh"

    periph_hub #(
        .CLOCK_MHZ (CLOCK_MHZ)
    ) dut0 (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .i_data_read_complete (read_complete),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_irq                (irq)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // Full slot window is 64 bytes, byte slot window is 16 bytes at region 2'b10
    function automatic logic [10:0] full_addr(input int slot, input int ofs);
        return {1'b0, slot[3:0], ofs[5:0]};
    endfunction

    function automatic logic [10:0] byte_addr(input int slot, input int ofs);
        return {2'b10, 1'b0, slot[3:0], ofs[3:0]};
    endfunction

    task automatic add_step(input op_e op, input logic [10:0] adr, input logic [31:0] d,
                            input logic [31:0] e, input string name);
        step_op.push_back(op);
        step_addr.push_back(adr);
        step_data.push_back(d);
        step_exp.push_back(e);
        step_name.push_back(name);
    endtask

    // Expiry lands N x CLOCK_MHZ edges after the loading edge
    task automatic check_timer(input int n);
        logic pin0_before;
        pin0_before = uo_out[0];
        bus_write(full_addr(SLOT_TIMER, 0), n);
        for (int i = 1; i <= n * CLOCK_MHZ; i++) begin
            if (irq !== 1'b0) begin
                report_mismatch("o_irq before expiry", 32'h0, {31'h0, irq});
            end
            next_cycle();
        end
        if (irq !== 1'b1) begin
            report_mismatch("o_irq at expiry", 32'h1, {31'h0, irq});
        end
        if (uo_out[0] !== ~pin0_before) begin
            report_mismatch("o_uo_out[0] toggle", {31'h0, ~pin0_before}, {31'h0, uo_out[0]});
        end
        bus_write(full_addr(SLOT_TIMER, 4), 32'h0);
        if (irq !== 1'b0) begin
            report_mismatch("o_irq after clear", 32'h0, {31'h0, irq});
        end
    endtask

    task automatic check_read_hold(input logic [7:0] val);
        logic [31:0] rd;
        int          lat;
        ui_in = val;
        next_cycle();
        addr   = full_addr(SLOT_GPIO, GPIO_OFS_IN);
        read_n = 2'b10;
        #1;
        if (data_ready !== 1'b0) begin
            report_mismatch("o_data_ready with request", 32'h0, {31'h0, data_ready});
        end
        next_cycle();
        if (data_ready !== 1'b1) begin
            report_mismatch("o_data_ready one cycle later", 32'h1, {31'h0, data_ready});
        end
        if (data_out !== {24'h0, val}) begin
            report_mismatch("o_data_out", {24'h0, val}, data_out);
        end
        // Pins move while the request is still held
        for (int i = 0; i < 4; i++) begin
            ui_in = ~val;
            next_cycle();
            if (data_out !== {24'h0, val}) begin
                report_mismatch("o_data_out while held", {24'h0, val}, data_out);
            end
            if (data_ready !== 1'b1) begin
                report_mismatch("o_data_ready while held", 32'h1, {31'h0, data_ready});
            end
        end
        read_n        = ACC_NONE;
        read_complete = 1'b1;
        next_cycle();
        read_complete = 1'b0;
        if (data_out !== {24'h0, val}) begin
            report_mismatch("o_data_out after complete", {24'h0, val}, data_out);
        end
        bus_read(full_addr(SLOT_GPIO, GPIO_OFS_IN), rd, lat);
        if (rd !== {24'h0, ~val}) begin
            report_mismatch("o_data_out on new read", {24'h0, ~val}, rd);
        end
    endtask

    initial begin
        logic [7:0]  gpio_byte;
        logic [7:0]  in_byte;
        logic [7:0]  duty_rand;
        logic [31:0] rd;
        int          lat;
        int          highs;
        int          pulses;
        int          timer_n;
        int          errors_before;
        int          failed_steps;

        void'($urandom(32'hc972));
        rst_n         = 1'b0;
        ui_in         = 8'h00;
        addr          = '0;
        data_in       = '0;
        write_n       = ACC_NONE;
        read_n        = ACC_NONE;
        read_complete = 1'b0;
        failed_steps  = 0;

        gpio_byte = $urandom;
        in_byte   = $urandom;
        pulses    = 1 + ($urandom % 20);
        timer_n   = 2 + ($urandom % 10);
        duty_rand = 1 + ($urandom % 254);

        add_step(OP_READ, full_addr(SLOT_GPIO, GPIO_OFS_SEL), 0, {27'h0, 1'b0, SLOT_TIMER},
                 "pin 0 select after reset");
        add_step(OP_READ, full_addr(SLOT_GPIO, GPIO_OFS_SEL + 20), 0, {27'h0, 1'b0, SLOT_GPIO},
                 "pin 5 select after reset");
        add_step(OP_WRITE, full_addr(SLOT_GPIO, GPIO_OFS_OUT), gpio_byte, 0, "GPIO out write");
        add_step(OP_READ, full_addr(SLOT_GPIO, GPIO_OFS_OUT), 0, gpio_byte, "GPIO out readback");
        add_step(OP_PINS, 0, 32'hfe, gpio_byte & 8'hfe, "GPIO pins 1-7");
        add_step(OP_SETIN, 0, in_byte, 0, "drive input pins");
        add_step(OP_READ, full_addr(SLOT_GPIO, GPIO_OFS_IN), 0, in_byte, "GPIO input read");
        add_step(OP_HOLD, 0, $urandom, 0, "read hold until complete");
        add_step(OP_SETIN, 0, 0, 0, "input pins low");
        add_step(OP_WRITE, byte_addr(SLOT_EDGE, 3), 0, 0, "clear counter 3");
        add_step(OP_PULSE, 3, pulses, 0, "pulses on pin 3");
        add_step(OP_READ, byte_addr(SLOT_EDGE, 3), 0, pulses, "counter 3 value");
        add_step(OP_WRITE, byte_addr(SLOT_EDGE, 3), 0, 0, "clear counter 3 again");
        add_step(OP_READ, byte_addr(SLOT_EDGE, 3), 0, 0, "counter 3 cleared");
        add_step(OP_TIMER, 0, timer_n, 0, "timer expiry and clear");
        add_step(OP_WRITE, full_addr(SLOT_GPIO, GPIO_OFS_SEL + 8), {1'b1, SLOT_PWM}, 0,
                 "route pin 2 to PWM");
        add_step(OP_PWM, 2, 0, 0, "PWM duty 0");
        add_step(OP_PWM, 2, 255, 255, "PWM duty 255");
        add_step(OP_PWM, 2, duty_rand, duty_rand, "PWM random duty");
        add_step(OP_READ, byte_addr(SLOT_PWM, 0), 0, duty_rand, "PWM duty readback");
        // Unused slots are read once the peripherals hold non-zero values
        add_step(OP_READ, full_addr(7, GPIO_OFS_SEL), 0, 0, "unused full slot");
        add_step(OP_READ, byte_addr(9, 0), 0, 0, "unused byte slot");

        cycle_limit = step_op.size() * CYCLES_PER_STEP;

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        for (int s = 0; s < step_op.size(); s++) begin
            errors_before = error_count;
            case (step_op[s])
                OP_WRITE: bus_write(step_addr[s], step_data[s]);
                OP_READ: begin
                    bus_read(step_addr[s], rd, lat);
                    if (rd !== step_exp[s]) begin
                        report_mismatch("o_data_out", step_exp[s], rd);
                    end
                end
                OP_SETIN: begin
                    ui_in = step_data[s][7:0];
                    next_cycle();
                end
                OP_PINS: begin
                    if ((uo_out & step_data[s][7:0]) !== step_exp[s][7:0]) begin
                        report_mismatch("o_uo_out", step_exp[s],
                                        {24'h0, uo_out & step_data[s][7:0]});
                    end
                end
                OP_PULSE: drive_pulses(step_addr[s], step_data[s]);
                OP_PWM: begin
                    bus_write(byte_addr(SLOT_PWM, 0), step_data[s]);
                    count_high_cycles(step_addr[s], highs);
                    if (highs != step_exp[s]) begin
                        report_mismatch("o_uo_out[2] high cycles", step_exp[s], highs);
                    end
                end
                OP_TIMER: check_timer(step_data[s]);
                OP_HOLD:  check_read_hold(step_data[s][7:0]);
                default:  report_problem("unknown step in the table");
            endcase
            if (error_count == errors_before) begin
                $display("Step %0d (%s): ok", s, step_name[s]);
            end else begin
                $display("Step %0d (%s): FAILED", s, step_name[s]);
                failed_steps++;
            end
        end

        $display("Summary: %0d steps, %0d failed, %0d errors", step_op.size(), failed_steps,
                 error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
periph_pkg.sv
periph_if.sv
bus_ctrl.sv
gpio_block.sv
event_timer.sv
edge_counter.sv
pwm_gen.sv
periph_hub.sv
tb_periph_hub.sv
